// File: design/powerPkg.sv
`default_nettype none

package powerPkg;

	//////////////////////////////////////////////////////////////////////
	// Operand and partial-product geometry
	//////////////////////////////////////////////////////////////////////

	// Signed I and Q operand width
	localparam int Width = 8;
	// One partial-product row and the width of a square
	localparam int RowWidth = 2 * Width;
	// Rows per operand from the signed squarer
	localparam int RowCount = Width / 2 + 1;
	// Flattened row set of one operand
	localparam int PPWidth = RowCount * RowWidth;
	// I^2 + Q^2 peaks at 2^15 and still fits
	localparam int PowerWidth = 2 * Width;
	localparam int TagWidth = 4;

	//////////////////////////////////////////////////////////////////////
	// Flow control
	//////////////////////////////////////////////////////////////////////

	// Input FIFO entries and upstream credits after reset
	localparam int QueueDepth = 4;
	// Output credits held after reset
	localparam int OutCredits = 4;
	localparam int PtrWidth = $clog2(QueueDepth);
	localparam int FillWidth = $clog2(QueueDepth + 1);
	localparam int CreditWidth = $clog2(OutCredits + 1);

	// One complex sample with its channel tag
	typedef struct packed {
		logic [TagWidth-1:0] tag;
		logic signed [Width-1:0] iVal;
		logic signed [Width-1:0] qVal;
	} sampleT;

endpackage

`default_nettype wire

// File: design/ppLink.sv
`timescale 1ns/100ps
`default_nettype none

// Issue stage to reduction stage
interface ppLink;
	import powerPkg::*;

	logic valid;
	logic [TagWidth-1:0] tag;
	// Flattened in-phase row set
	logic [PPWidth-1:0] ppI;
	// Flattened quadrature row set
	logic [PPWidth-1:0] ppQ;

	// Link register side
	modport source (
		output valid, tag, ppI, ppQ
	);

	// Reducer side
	modport sink (
		input valid, tag, ppI, ppQ
	);

endinterface

`default_nettype wire

// File: design/sampleQueue.sv
`timescale 1ns/100ps
`default_nettype none

module sampleQueue (
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  powerPkg::sampleT inSample,
	input  logic outCredit,
	output powerPkg::sampleT head,
	output logic issue,
	output logic inCredit
);
	import powerPkg::*;

	// Sample storage
	sampleT mem [QueueDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	// Occupancy from 0 to QueueDepth
	logic [FillWidth-1:0] fill;
	// Output credits still held
	logic [CreditWidth-1:0] creditCnt;

	// Pop only with a sample and room downstream
	assign issue = (fill != '0) && (creditCnt != '0);
	assign head = mem[rdPtr];

	//////////////////////////////////////////////////////////////////////
	// Storage write
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (inValid) begin
			mem[wrPtr] <= inSample;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
		end else begin
			// Pointers wrap at QueueDepth
			if (inValid) begin
				wrPtr <= (wrPtr == PtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (issue) begin
				rdPtr <= (rdPtr == PtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			fill <= fill + FillWidth'(inValid) - FillWidth'(issue);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Credits in both directions
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			inCredit <= 1'b0;
			creditCnt <= CreditWidth'(OutCredits);
		end else begin
			// One upstream credit per popped entry
			inCredit <= issue;
			// Issue spends and outCredit refunds so that both together cancel
			case ({issue, outCredit})
				2'b10: creditCnt <= creditCnt - 1'b1;
				2'b01: creditCnt <= creditCnt + 1'b1;
				default: creditCnt <= creditCnt;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/sqrPPGenSgn.sv
`timescale 1ns/100ps
`default_nettype none

// Rows of a signed square whose plain modulo sum gives x*x
module sqrPPGenSgn #(
	parameter int width = 8
) (
	input  logic [width-1:0] x,
	output logic [(width/2+1)*2*width-1:0] pp
);

	localparam int rowW = 2 * width;
	localparam int rows = width / 2 + 1;
	localparam int msb = width - 1;

	logic [rowW-1:0] row [rows];

	always_comb begin
		for (int r = 0; r < rows; r++) begin
			row[r] = '0;
		end

		// Cross terms below the sign row taken once at doubled weight
		for (int i = 0; i < msb / 2; i++) begin
			for (int k = i + 1; k < msb - i; k++) begin
				row[i][i+k+1] = x[i] & x[k];
			end
		end

		// Inverted sign row turns the negative weight into a plain add
		for (int k = 0; k < msb; k++) begin
			row[0][width+k] = x[msb] & ~x[k];
		end

		// Remaining upper cross terms folded into higher rows
		for (int i = 1; i < width / 2; i++) begin
			for (int k = i; k < msb - i; k++) begin
				row[i][width-i+k] = x[msb-i] & x[k];
			end
		end

		// Diagonal bits since x(i)*x(i) is just x(i)
		for (int i = 0; i <= msb / 2; i++) begin
			row[i][2*i] = x[i];
		end
		for (int i = 1; i <= width / 2; i++) begin
			row[i][rowW-2*i] = x[width-i];
		end

		// Constants completing the two's complement of the sign row
		row[0][rowW-1] = ~x[msb];
		row[1][rowW-1] = 1'b1;
		if (width % 2 == 0) begin
			row[width/2-1][msb] = x[msb];
			row[width/2][msb] = x[msb];
		end else begin
			row[width/2][width] = x[msb];
		end

		// Flatten with row 0 in the low bits
		for (int r = 0; r < rows; r++) begin
			pp[r*rowW +: rowW] = row[r];
		end
	end

endmodule

`default_nettype wire

// File: design/ppReduce.sv
`timescale 1ns/100ps
`default_nettype none

module ppReduce (
	input  logic clk,
	input  logic rst,
	ppLink.sink link,
	output logic outValid,
	output logic [powerPkg::TagWidth-1:0] outTag,
	output logic [powerPkg::PowerWidth-1:0] outPower
);
	import powerPkg::*;

	// Both operands' rows in one pool
	localparam int TotalRows = 2 * RowCount;

	logic [PowerWidth-1:0] rowArr [TotalRows];
	logic [PowerWidth-1:0] sumNext;
	logic [PowerWidth-1:0] carryNext;
	// Carry-save stage registers
	logic [PowerWidth-1:0] sumR;
	logic [PowerWidth-1:0] carryR;
	logic [TagWidth-1:0] tagR;
	logic validR;

	// I rows first and Q rows after
	always_comb begin
		for (int r = 0; r < RowCount; r++) begin
			rowArr[r] = link.ppI[r*RowWidth +: RowWidth];
			rowArr[RowCount+r] = link.ppQ[r*RowWidth +: RowWidth];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Layered 3:2 compression down to sum and carry
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		logic [PowerWidth-1:0] lvl [TotalRows];
		logic [PowerWidth-1:0] nxt [TotalRows];
		int n;
		int g;
		lvl = rowArr;
		n = TotalRows;
		g = 0;
		for (int l = 0; l < TotalRows; l++) begin
			if (n > 2) begin
				g = n / 3;
				for (int k = 0; k < TotalRows; k++) begin
					nxt[k] = '0;
				end
				// Full-adder row per group of three
				for (int k = 0; k < TotalRows / 3; k++) begin
					if (k < g) begin
						nxt[2*k] = lvl[3*k] ^ lvl[3*k+1] ^ lvl[3*k+2];
						// MSB carry drops off since the sum is modulo 2^PowerWidth
						nxt[2*k+1] = ((lvl[3*k] & lvl[3*k+1]) | (lvl[3*k] & lvl[3*k+2])
							| (lvl[3*k+1] & lvl[3*k+2])) << 1;
					end
				end
				// Up to two leftover rows pass straight down
				for (int k = 0; k < 2; k++) begin
					if (3 * g + k < n) begin
						nxt[2*g+k] = lvl[3*g+k];
					end
				end
				n = n - g;
				lvl = nxt;
			end
		end
		sumNext = lvl[0];
		carryNext = lvl[1];
	end

	//////////////////////////////////////////////////////////////////////
	// Carry-save register then final add
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			validR <= 1'b0;
			outValid <= 1'b0;
		end else begin
			validR <= link.valid;
			outValid <= validR;
		end
	end

	always_ff @(posedge clk) begin
		sumR <= sumNext;
		carryR <= carryNext;
		tagR <= link.tag;
		// Carry-propagate add is exact since the power fits
		outPower <= sumR + carryR;
		outTag <= tagR;
	end

endmodule

`default_nettype wire

// File: design/powerDetect.sv
`timescale 1ns/100ps
`default_nettype none

module powerDetect (
	input  logic clk,
	input  logic rst,
	// Upstream
	input  logic inValid,
	input  logic [powerPkg::TagWidth-1:0] inTag,
	input  logic signed [powerPkg::Width-1:0] inI,
	input  logic signed [powerPkg::Width-1:0] inQ,
	output logic inCredit,
	// Downstream
	output logic outValid,
	output logic [powerPkg::TagWidth-1:0] outTag,
	output logic [powerPkg::PowerWidth-1:0] outPower,
	input  logic outCredit
);
	import powerPkg::*;

	sampleT inSample;
	sampleT head;
	logic issue;
	// Row sets from the squarers off the queue head
	logic [PPWidth-1:0] ppINext;
	logic [PPWidth-1:0] ppQNext;

	assign inSample = '{tag: inTag, iVal: inI, qVal: inQ};

	sampleQueue sampleQueue_i (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inSample(inSample),
		.outCredit(outCredit),
		.head(head),
		.issue(issue),
		.inCredit(inCredit)
	);

	// I and Q squared side by side
	sqrPPGenSgn #(.width(Width)) sqrPPGenI_i (.x(head.iVal), .pp(ppINext));
	sqrPPGenSgn #(.width(Width)) sqrPPGenQ_i (.x(head.qVal), .pp(ppQNext));

	ppLink link ();

	//////////////////////////////////////////////////////////////////////
	// Link register loaded on issue
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			link.valid <= 1'b0;
		end else begin
			link.valid <= issue;
		end
	end

	// Payload holds between issues
	always_ff @(posedge clk) begin
		if (issue) begin
			link.tag <= head.tag;
			link.ppI <= ppINext;
			link.ppQ <= ppQNext;
		end
	end

	ppReduce ppReduce_i (
		.clk(clk),
		.rst(rst),
		.link(link.sink),
		.outValid(outValid),
		.outTag(outTag),
		.outPower(outPower)
	);

endmodule

`default_nettype wire

// File: test/powerDetect_sva.sv
`timescale 1ns/100ps
`default_nettype none

module powerDetect_sva (
	input wire logic clk,
	input wire logic rst,
	input wire logic inValid,
	input wire logic issue,
	input wire logic outCredit,
	input wire logic outValid,
	input wire logic [powerPkg::FillWidth-1:0] fill,
	input wire logic [powerPkg::CreditWidth-1:0] creditCnt
);
	import powerPkg::*;

	// Assertion failures so far
	int failCount = 0;
	// Credits spent and not yet returned
	int spent;

	always_ff @(posedge clk) begin
		if (rst) begin
			spent <= 0;
		end else begin
			spent <= spent + int'(issue) - int'(outCredit);
		end
	end

	// No write into a full queue unless the head leaves
	noOverflow: assert property (@(posedge clk) disable iff (rst)
		!(inValid && fill == FillWidth'(QueueDepth) && !issue))
		else begin
			failCount++;
			$error("queue overflow");
		end

	creditBound: assert property (@(posedge clk) disable iff (rst)
		creditCnt <= CreditWidth'(OutCredits))
		else begin
			failCount++;
			$error("output credits above limit");
		end

	issueCredit: assert property (@(posedge clk) disable iff (rst)
		issue |-> spent < OutCredits)
		else begin
			failCount++;
			$error("issue without credit");
		end

	// Held in reset since the previous edge
	resetQuiet: assert property (@(posedge clk) rst && $past(rst) |-> !outValid)
		else begin
			failCount++;
			$error("outValid high in reset");
		end

endmodule

bind powerDetect powerDetect_sva powerDetect_sva_i (
	.clk(clk),
	.rst(rst),
	.inValid(inValid),
	.issue(issue),
	.outCredit(outCredit),
	.outValid(outValid),
	.fill(sampleQueue_i.fill),
	.creditCnt(sampleQueue_i.creditCnt)
);

`default_nettype wire

// File: test/powerDetectTb.sv
`timescale 1ns/100ps
`default_nettype none

module powerDetectTb;
	import powerPkg::*;

	// Samples per test that also size the run limit
	localparam int CornerCount = 25;
	localparam int RandomCount = 300;
	localparam int HeldCount = OutCredits + QueueDepth;
	localparam int RunLimit = 40 * (CornerCount + RandomCount + 1 + HeldCount) + 200;

	logic clk = 1'b0;
	logic rst;
	logic inValid;
	logic [TagWidth-1:0] inTag;
	logic signed [Width-1:0] inI;
	logic signed [Width-1:0] inQ;
	logic inCredit;
	logic outValid;
	logic [TagWidth-1:0] outTag;
	logic [PowerWidth-1:0] outPower;
	logic outCredit;

	// Pending stimulus with expected {tag, power} and credit return times
	sampleT txQ[$];
	logic [TagWidth+PowerWidth-1:0] expQ[$];
	int retQ[$];
	int upCredits = QueueDepth;
	int sent = 0;
	int results = 0;
	int held = 0;
	int tick = 0;
	int cycles = 0;
	int errors = 0;
	int tests = 0;
	int sentBase;
	int resBase;
	int errBase;
	bit holdCredits = 1'b0;
	int creditDelay = 0;
	int seed = 32'h6c80_c7b3;

	always #10 clk = ~clk;

	powerDetect powerDetect_i (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inTag(inTag),
		.inI(inI),
		.inQ(inQ),
		.inCredit(inCredit),
		.outValid(outValid),
		.outTag(outTag),
		.outPower(outPower),
		.outCredit(outCredit)
	);

	// I squared plus Q squared at full precision
	function automatic int power(input logic signed [Width-1:0] i,
			input logic signed [Width-1:0] q);
		int a;
		int b;
		a = i;
		b = q;
		return a * a + b * b;
	endfunction

	task automatic compareVal(input string name, input logic signed [31:0] got,
			input logic signed [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic queueSample(input int tag, input int i, input int q);
		sampleT s;
		s.tag = TagWidth'(tag);
		s.iVal = Width'(i);
		s.qVal = Width'(q);
		txQ.push_back(s);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Upstream driver spending one credit per sample
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin : drive
		sampleT s;
		if (rst) begin
			inValid <= 1'b0;
			upCredits = QueueDepth;
		end else begin
			if (inCredit) begin
				upCredits++;
			end
			if (txQ.size() > 0 && upCredits > 0) begin
				s = txQ.pop_front();
				inValid <= 1'b1;
				inTag <= s.tag;
				inI <= s.iVal;
				inQ <= s.qVal;
				expQ.push_back({s.tag, PowerWidth'(power(s.iVal, s.qVal))});
				upCredits--;
				sent++;
			end else begin
				inValid <= 1'b0;
			end
		end
	end

	// Scoreboard pops one expected entry per result
	always @(posedge clk) begin : compare
		logic [TagWidth+PowerWidth-1:0] e;
		if (!rst && outValid) begin
			results++;
			if (expQ.size() == 0) begin
				$display("Result at %0t arrived with no sample outstanding", $time);
				errors++;
			end else begin
				e = expQ.pop_front();
				compareVal("outTag", outTag, e[PowerWidth +: TagWidth]);
				compareVal("outPower", outPower, e[PowerWidth-1:0]);
			end
		end
	end

	// Downstream returns each credit creditDelay cycles after its result
	always @(posedge clk) begin : downstream
		tick++;
		if (rst) begin
			outCredit <= 1'b0;
		end else begin
			if (outValid) begin
				retQ.push_back(tick + creditDelay);
				held++;
				if (held > OutCredits) begin
					$display("Downstream got more results than it has credits at %0t", $time);
					errors++;
				end
			end
			if (!holdCredits && retQ.size() > 0 && retQ[0] <= tick) begin
				retQ.delete(0);
				outCredit <= 1'b1;
				held--;
			end else begin
				outCredit <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin : watchdog
		cycles++;
		if (cycles >= RunLimit) begin
			$display("Run did not finish within %0d cycles", RunLimit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequencing
	//////////////////////////////////////////////////////////////////////

	task automatic startTest;
		sentBase = sent;
		resBase = results;
		errBase = errors;
	endtask

	// Wait until everything is sent and checked and all credits are home
	task automatic waitDrained;
		do begin
			@(negedge clk);
		end while (txQ.size() > 0 || expQ.size() > 0 || retQ.size() > 0 || outCredit);
	endtask

	task automatic endTest(input string name);
		compareVal("upstream credits", upCredits, QueueDepth);
		compareVal("result count", results - resBase, sent - sentBase);
		tests++;
		$display("Test %s: %0d samples, %0d errors", name, sent - sentBase, errors - errBase);
	endtask

	initial begin : main
		int vals [5];
		int a;
		int c;
		int o;
		int n;
		bit quiet;
		vals = '{-128, -1, 0, 1, 127};
		rst = 1'b1;
		inValid = 1'b0;
		inTag = '0;
		inI = '0;
		inQ = '0;
		outCredit = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);

		// Every corner pair including the 2^15 peak
		startTest();
		for (int x = 0; x < 5; x++) begin
			for (int y = 0; y < 5; y++) begin
				queueSample(x * 5 + y, vals[x], vals[y]);
			end
		end
		waitDrained();
		endTest("corners");

		// Full rate with credits returned at once
		startTest();
		for (int k = 0; k < RandomCount; k++) begin
			queueSample($random(seed), $random(seed), $random(seed));
		end
		waitDrained();
		endTest("random stream");

		// Idle detector with edges counted from acceptance
		startTest();
		queueSample(9, 7, -3);
		n = 0;
		a = -1;
		c = -1;
		o = -1;
		while (o < 0) begin
			@(negedge clk);
			n++;
			if (a < 0 && inValid) a = n;
			if (a >= 0 && c < 0 && inCredit) c = n;
			if (a >= 0 && outValid) o = n;
		end
		// Accepting edge sits right after negedge a
		compareVal("inCredit latency", c - (a + 1), 1);
		compareVal("outValid latency", o - (a + 1), 3);
		waitDrained();
		endTest("latency");

		// Credits withheld until queue and upstream fill up
		startTest();
		holdCredits = 1'b1;
		creditDelay = 2;
		for (int k = 0; k < HeldCount; k++) begin
			queueSample(k, $random(seed), $random(seed));
		end
		while (txQ.size() > 0 || results - resBase < OutCredits) @(negedge clk);
		quiet = 1'b1;
		repeat (8) begin
			@(negedge clk);
			if (inCredit || outValid) quiet = 1'b0;
		end
		compareVal("results while held", results - resBase, OutCredits);
		compareVal("credits while held", upCredits, 0);
		compareVal("quiet while held", quiet, 1);
		holdCredits = 1'b0;
		waitDrained();
		endTest("back-pressure");

		// Add the assertion failures
		errors += powerDetect_i.powerDetect_sva_i.failCount;
		$display("Summary: %0d tests, %0d sent, %0d results, %0d errors",
			tests, sent, results, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
design/powerPkg.sv
design/ppLink.sv
design/sampleQueue.sv
design/sqrPPGenSgn.sv
design/ppReduce.sv
design/powerDetect.sv
test/powerDetect_sva.sv
test/powerDetectTb.sv

// File: Bender.yml
package:
  name: power_detect

sources:
  - design/powerPkg.sv
  - design/ppLink.sv
  - design/sampleQueue.sv
  - design/sqrPPGenSgn.sv
  - design/ppReduce.sv
  - design/powerDetect.sv
  - target: test
    files:
      - test/powerDetect_sva.sv
      - test/powerDetectTb.sv
